// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ntm_activation_trainer_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

# Rebuilt only when a source, header or the file list changes
$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG)

check:
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/ntm_cfg.svh ====
`ifndef NTM_CFG_SVH
`define NTM_CFG_SVH

// Width of one residue word
`define NTM_DATA_WIDTH 32

// Width of the sample counters
`define NTM_COUNT_WIDTH 16

// Prime modulus, largest 32-bit prime
`define NTM_MODULUS 32'hFFFF_FFFB

`endif

// ==== rtl/ntm_activation_derivative.sv ====
`timescale 1ns/1ps

`include "ntm_cfg.svh"

module ntm_activation_derivative (
  input  logic           CLK,
  input  logic           RST,
  input  logic           start,
  input  ntm_pkg::word_t a_in,
  input  ntm_pkg::word_t i_in,
  input  ntm_pkg::word_t s_in,
  input  logic           da_take,
  output logic           idle,
  output logic           da_valid,
  output ntm_pkg::word_t da
);

  import ntm_pkg::*;

  deriv_state_e state;

  // Latched operands, a goes straight to the multiplier on start
  word_t i_r;
  word_t s_r;
  word_t one_minus_sq;
  word_t da_r;

  // Multiplier port
  logic  mul_start;
  word_t mul_a;
  word_t mul_b;
  logic  mul_ready;
  word_t mul_product;

  ////////////////////
  // Multiplier sequencing
  ////////////////////

  // Each product starts on the ready cycle of the one before
  always_comb begin
    mul_start = 1'b0;
    mul_a     = '0;
    mul_b     = '0;
    case (state)
      DER_IDLE: begin
        // a squared
        mul_start = start;
        mul_a     = a_in;
        mul_b     = a_in;
      end
      DER_SQUARE: begin
        // s times i
        mul_start = mul_ready;
        mul_a     = s_r;
        mul_b     = i_r;
      end
      DER_SI: begin
        // (s*i) times (1 - a^2), product still valid this cycle
        mul_start = mul_ready;
        mul_a     = mul_product;
        mul_b     = one_minus_sq;
      end
      default: begin
        mul_start = 1'b0;
      end
    endcase
  end

  ntm_modular_multiplier u_mul (
    .CLK     (CLK),
    .RST     (RST),
    .start   (mul_start),
    .op_a    (mul_a),
    .op_b    (mul_b),
    .ready   (mul_ready),
    .product (mul_product)
  );

  ////////////////////
  // Payload
  ////////////////////

  always_ff @(posedge CLK) begin
    if (state == DER_IDLE && start) begin
      i_r <= i_in;
      s_r <= s_in;
    end
    // 1 - a^2 mod P, wraps through P when a^2 exceeds 1
    if (state == DER_SQUARE && mul_ready) begin
      if (mul_product > word_t'(1)) begin
        one_minus_sq <= `NTM_MODULUS - mul_product + word_t'(1);
      end else begin
        one_minus_sq <= word_t'(1) - mul_product;
      end
    end
    if (state == DER_PRODUCT && mul_ready) begin
      da_r <= mul_product;
    end
  end

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= DER_IDLE;
    end else begin
      case (state)
        DER_IDLE:    if (start) state <= DER_SQUARE;
        DER_SQUARE:  if (mul_ready) state <= DER_SI;
        DER_SI:      if (mul_ready) state <= DER_PRODUCT;
        DER_PRODUCT: if (mul_ready) state <= DER_HOLD;
        // Wait for the accumulator to pick it up
        DER_HOLD:    if (da_take) state <= DER_IDLE;
        default:     state <= DER_IDLE;
      endcase
    end
  end

  assign idle     = (state == DER_IDLE);
  assign da_valid = (state == DER_HOLD);
  assign da       = da_r;

endmodule

// ==== rtl/ntm_activation_trainer.sv ====
`timescale 1ns/1ps

module ntm_activation_trainer (
  input  logic            CLK,
  input  logic            RST,
  input  logic            start,
  input  ntm_pkg::count_t length_in,
  output logic            sample_ready,
  input  logic            in_enable,
  input  ntm_pkg::word_t  a_in,
  input  ntm_pkg::word_t  i_in,
  input  ntm_pkg::word_t  s_in,
  input  ntm_pkg::word_t  x_in,
  input  ntm_pkg::word_t  h_in,
  output logic            ready,
  output ntm_pkg::word_t  w_out,
  output ntm_pkg::word_t  k_out,
  output ntm_pkg::word_t  b_out
);

  import ntm_pkg::*;

  trainer_state_e state;
  trainer_state_e state_next;

  count_t length_r;
  count_t accepted_cnt;
  count_t done_cnt;

  // Run start is honoured in idle and on the ready cycle
  logic run_start;
  logic accept;
  logic all_done;

  // x and h wait here while da is computed
  word_t x_r;
  word_t h_r;
  logic  first_r;

  // Derivative unit
  logic  der_idle;
  logic  der_valid;
  word_t der_da;

  // Accumulator
  logic  da_take;
  logic  acc_busy;
  logic  acc_busy_q;
  logic  busy_fall;
  word_t w_sum;
  word_t k_sum;
  word_t b_sum;

  assign run_start    = start && (state == TRN_IDLE || state == TRN_DONE);
  assign sample_ready = (state == TRN_STREAM) && (accepted_cnt < length_r) && der_idle;
  assign accept       = in_enable && sample_ready;
  assign da_take      = der_valid && !acc_busy;
  assign busy_fall    = acc_busy_q && !acc_busy;
  assign all_done     = (done_cnt == length_r);

  ////////////////////
  // Units
  ////////////////////

  ntm_activation_derivative u_derivative (
    .CLK      (CLK),
    .RST      (RST),
    .start    (accept),
    .a_in     (a_in),
    .i_in     (i_in),
    .s_in     (s_in),
    .da_take  (da_take),
    .idle     (der_idle),
    .da_valid (der_valid),
    .da       (der_da)
  );

  ntm_gradient_accumulator u_accumulator (
    .CLK        (CLK),
    .RST        (RST),
    .clear      (run_start),
    .da_take    (da_take),
    .first_step (first_r),
    .da         (der_da),
    .x_in       (x_r),
    .h_in       (h_r),
    .busy       (acc_busy),
    .w_sum      (w_sum),
    .k_sum      (k_sum),
    .b_sum      (b_sum)
  );

  always_ff @(posedge CLK) begin
    if (accept) begin
      x_r <= x_in;
      h_r <= h_in;
    end
  end

  ////////////////////
  // Run FSM
  ////////////////////

  always_comb begin
    state_next = state;
    case (state)
      TRN_STREAM: begin
        // All accepted, maybe all accumulated too (length 0)
        if (accepted_cnt == length_r) begin
          state_next = all_done ? TRN_DONE : TRN_DRAIN;
        end
      end
      TRN_DRAIN: if (all_done) state_next = TRN_DONE;
      TRN_DONE:  state_next = TRN_IDLE;
      default:   state_next = TRN_IDLE;
    endcase
    if (run_start) begin
      state_next = TRN_STREAM;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= TRN_IDLE;
      length_r     <= '0;
      accepted_cnt <= '0;
      done_cnt     <= '0;
      first_r      <= 1'b0;
      acc_busy_q   <= 1'b0;
      w_out        <= '0;
      k_out        <= '0;
      b_out        <= '0;
    end else begin
      state      <= state_next;
      acc_busy_q <= acc_busy;
      if (run_start) begin
        length_r     <= length_in;
        accepted_cnt <= '0;
        done_cnt     <= '0;
      end else begin
        // Sample 0 has no previous h
        if (accept) begin
          accepted_cnt <= accepted_cnt + 1'b1;
          first_r      <= (accepted_cnt == '0);
        end
        // One sample fully accumulated
        if (busy_fall) begin
          done_cnt <= done_cnt + 1'b1;
        end
      end
      // Results held until the next run
      if (state_next == TRN_DONE && state != TRN_DONE) begin
        w_out <= w_sum;
        k_out <= k_sum;
        b_out <= b_sum;
      end
    end
  end

  assign ready = (state == TRN_DONE);

endmodule

// ==== rtl/ntm_gradient_accumulator.sv ====
`timescale 1ns/1ps

`include "ntm_cfg.svh"

module ntm_gradient_accumulator (
  input  logic           CLK,
  input  logic           RST,
  input  logic           clear,
  input  logic           da_take,
  input  logic           first_step,
  input  ntm_pkg::word_t da,
  input  ntm_pkg::word_t x_in,
  input  ntm_pkg::word_t h_in,
  output logic           busy,
  output ntm_pkg::word_t w_sum,
  output ntm_pkg::word_t k_sum,
  output ntm_pkg::word_t b_sum
);

  import ntm_pkg::*;

  accum_state_e state;

  // Sample held for the duration of the update
  word_t da_r;
  word_t h_r;
  logic  first_r;

  // h of the previous step, pairs with the current da
  word_t h_prev;

  // Multiplier port
  logic  mul_start;
  word_t mul_a;
  word_t mul_b;
  logic  mul_ready;
  word_t mul_product;

  // Sum of two residues, one subtract at most
  function automatic word_t mod_add(input word_t x, input word_t y);
    logic [`NTM_DATA_WIDTH:0] s;
    s = {1'b0, x} + {1'b0, y};
    if (s >= {1'b0, `NTM_MODULUS}) begin
      s = s - {1'b0, `NTM_MODULUS};
    end
    mod_add = word_t'(s);
  endfunction

  ////////////////////
  // Multiplier control
  ////////////////////

  always_comb begin
    mul_start = 1'b0;
    mul_a     = da;
    mul_b     = x_in;
    if (state == ACC_IDLE) begin
      // da * x
      mul_start = da_take;
    end else if (state == ACC_WX) begin
      // da * h(t-1), skipped on the first step
      mul_start = mul_ready && !first_r;
      mul_a     = da_r;
      mul_b     = h_prev;
    end
  end

  ntm_modular_multiplier u_mul (
    .CLK     (CLK),
    .RST     (RST),
    .start   (mul_start),
    .op_a    (mul_a),
    .op_b    (mul_b),
    .ready   (mul_ready),
    .product (mul_product)
  );

  always_ff @(posedge CLK) begin
    if (state == ACC_IDLE && da_take) begin
      da_r    <= da;
      h_r     <= h_in;
      first_r <= first_step;
    end
  end

  ////////////////////
  // Sums and FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= ACC_IDLE;
      w_sum  <= '0;
      k_sum  <= '0;
      b_sum  <= '0;
      h_prev <= '0;
    end else if (clear) begin
      // New run
      state  <= ACC_IDLE;
      w_sum  <= '0;
      k_sum  <= '0;
      b_sum  <= '0;
      h_prev <= '0;
    end else begin
      case (state)
        ACC_IDLE: if (da_take) state <= ACC_WX;
        ACC_WX: begin
          if (mul_ready) begin
            w_sum <= mod_add(w_sum, mul_product);
            b_sum <= mod_add(b_sum, da_r);
            state <= first_r ? ACC_SUM : ACC_KH;
          end
        end
        ACC_KH: begin
          if (mul_ready) begin
            k_sum <= mod_add(k_sum, mul_product);
            state <= ACC_SUM;
          end
        end
        ACC_SUM: begin
          // Shift h along for the next step
          h_prev <= h_r;
          state  <= ACC_IDLE;
        end
        default: state <= ACC_IDLE;
      endcase
    end
  end

  assign busy = (state != ACC_IDLE);

endmodule

// ==== rtl/ntm_modular_multiplier.sv ====
`timescale 1ns/1ps

`include "ntm_cfg.svh"

module ntm_modular_multiplier (
  input  logic           CLK,
  input  logic           RST,
  input  logic           start,
  input  ntm_pkg::word_t op_a,
  input  ntm_pkg::word_t op_b,
  output logic           ready,
  output ntm_pkg::word_t product
);

  import ntm_pkg::*;

  mul_state_e state;
  logic [$clog2(`NTM_DATA_WIDTH)-1:0] bit_idx;

  // Operands and running partial sum
  word_t a_r;
  word_t b_r;
  word_t acc;

  word_t dbl_mod;
  word_t step_mod;

  // One conditional subtract brings a sum of two residues below P
  function automatic word_t mod_reduce(input logic [`NTM_DATA_WIDTH:0] v);
    logic [`NTM_DATA_WIDTH:0] p_wide;
    p_wide = {1'b0, `NTM_MODULUS};
    if (v >= p_wide) begin
      mod_reduce = word_t'(v - p_wide);
    end else begin
      mod_reduce = word_t'(v);
    end
  endfunction

  ////////////////////
  // Datapath
  ////////////////////

  // Double, then add a when the current bit of b is set
  always_comb begin
    dbl_mod = mod_reduce({acc, 1'b0});
    if (b_r[bit_idx]) begin
      step_mod = mod_reduce({1'b0, dbl_mod} + {1'b0, a_r});
    end else begin
      step_mod = dbl_mod;
    end
  end

  // Payload, loaded on an accepted start
  always_ff @(posedge CLK) begin
    if (start && state != MUL_RUN) begin
      // op_a may be above P, fold it once
      a_r <= mod_reduce({1'b0, op_a});
      b_r <= op_b;
      acc <= '0;
    end else if (state == MUL_RUN) begin
      acc <= step_mod;
    end
  end

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= MUL_IDLE;
      bit_idx <= '0;
    end else begin
      case (state)
        MUL_RUN: begin
          // MSB first, one bit per cycle
          if (bit_idx == '0) begin
            state <= MUL_DONE;
          end else begin
            bit_idx <= bit_idx - 1'b1;
          end
        end
        default: begin
          // Idle or done, a new start may chain straight in
          if (start) begin
            state   <= MUL_RUN;
            bit_idx <= '1;
          end else begin
            state <= MUL_IDLE;
          end
        end
      endcase
    end
  end

  assign ready   = (state == MUL_DONE);
  assign product = acc;

endmodule

// ==== rtl/ntm_pkg.sv ====
`include "ntm_cfg.svh"

package ntm_pkg;

  // Residue word and sample count
  typedef logic [`NTM_DATA_WIDTH-1:0] word_t;
  typedef logic [`NTM_COUNT_WIDTH-1:0] count_t;

  // Shift-add multiplier
  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_RUN,
    MUL_DONE
  } mul_state_e;

  // Derivative sequencer
  typedef enum logic [2:0] {
    DER_IDLE,
    DER_SQUARE,
    DER_SI,
    DER_PRODUCT,
    DER_HOLD
  } deriv_state_e;

  // Gradient accumulator
  typedef enum logic [1:0] {
    ACC_IDLE,
    ACC_WX,
    ACC_KH,
    ACC_SUM
  } accum_state_e;

  // Run control at the top
  typedef enum logic [1:0] {
    TRN_IDLE,
    TRN_STREAM,
    TRN_DRAIN,
    TRN_DONE
  } trainer_state_e;

endpackage

// ==== tb.f ====
+incdir+include
rtl/ntm_pkg.sv
rtl/ntm_modular_multiplier.sv
rtl/ntm_activation_derivative.sv
rtl/ntm_gradient_accumulator.sv
rtl/ntm_activation_trainer.sv
verif/ntm_activation_trainer_sva.sv
verif/ntm_activation_trainer_tb.sv

// ==== verif/ntm_activation_trainer_sva.sv ====
`timescale 1ns/1ps

`include "ntm_cfg.svh"

module ntm_activation_trainer_sva (
  input logic           CLK,
  input logic           RST,
  input logic           in_enable,
  input logic           sample_ready,
  input logic           ready,
  input ntm_pkg::word_t w_out,
  input ntm_pkg::word_t k_out,
  input ntm_pkg::word_t b_out
);

  ////////////////////
  // Handshake
  ////////////////////

  // ready is a single-cycle pulse
  a_ready_pulse: assert property (@(posedge CLK) disable iff (RST)
    ready |=> !ready)
    else $error("ready stayed high for two cycles");

  // Source may only send while the trainer asks
  a_enable_when_ready: assert property (@(posedge CLK) disable iff (RST)
    in_enable |-> sample_ready)
    else $error("in_enable asserted while sample_ready was low");

  // Accepted sample closes the window
  a_ready_drops: assert property (@(posedge CLK) disable iff (RST)
    (in_enable && sample_ready) |=> !sample_ready)
    else $error("sample_ready still high after an accepted sample");

  ////////////////////
  // Results
  ////////////////////

  // Sums are reduced residues
  a_sums_reduced: assert property (@(posedge CLK) disable iff (RST)
    ready |-> (w_out < `NTM_MODULUS && k_out < `NTM_MODULUS && b_out < `NTM_MODULUS))
    else $error("an output sum is not below the modulus");

endmodule

bind ntm_activation_trainer ntm_activation_trainer_sva u_sva (
  .CLK          (CLK),
  .RST          (RST),
  .in_enable    (in_enable),
  .sample_ready (sample_ready),
  .ready        (ready),
  .w_out        (w_out),
  .k_out        (k_out),
  .b_out        (b_out)
);

// ==== verif/ntm_activation_trainer_tb.sv ====
`timescale 1ns/1ps

`include "ntm_cfg.svh"

module ntm_activation_trainer_tb;

  import ntm_pkg::*;

  // Run lengths
  localparam int MAX_LEN    = 16;
  localparam int LEN_SINGLE = 1;
  localparam int LEN_RANDOM = 8;
  localparam int LEN_CORNER = 6;
  localparam int LEN_GAPS   = 6;
  localparam int NUM_RUNS   = 6;
  // 250 cycles per sample plus 100 per run
  localparam int CYCLE_LIMIT =
    (LEN_SINGLE + LEN_RANDOM + LEN_CORNER + 2 * LEN_GAPS) * 250 + NUM_RUNS * 100;
  localparam int SAMPLE_WAIT_LIMIT = 400;
  localparam logic [63:0] MOD64 = {32'h0, `NTM_MODULUS};

  logic   CLK = 1'b0;
  logic   RST;
  logic   start;
  count_t length_in;
  logic   sample_ready;
  logic   in_enable;
  word_t  a_in;
  word_t  i_in;
  word_t  s_in;
  word_t  x_in;
  word_t  h_in;
  logic   ready;
  word_t  w_out;
  word_t  k_out;
  word_t  b_out;

  // Samples of the current run
  word_t samp_a [MAX_LEN];
  word_t samp_i [MAX_LEN];
  word_t samp_s [MAX_LEN];
  word_t samp_x [MAX_LEN];
  word_t samp_h [MAX_LEN];

  // Expected sums filled before start
  word_t exp_w;
  word_t exp_k;
  word_t exp_b;
  string cur_test = "reset";
  int    runs_started = 0;
  int    runs_checked = 0;
  int    cycle_cnt = 0;

  always #50 CLK = ~CLK;

  ntm_activation_trainer u_ntm_activation_trainer (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .length_in    (length_in),
    .sample_ready (sample_ready),
    .in_enable    (in_enable),
    .a_in         (a_in),
    .i_in         (i_in),
    .s_in         (s_in),
    .x_in         (x_in),
    .h_in         (h_in),
    .ready        (ready),
    .w_out        (w_out),
    .k_out        (k_out),
    .b_out        (b_out)
  );

  ////////////////////
  // Reference model
  ////////////////////

  // Plain 64-bit product and remainder
  function automatic word_t model_mod_mul(input word_t x, input word_t y);
    logic [63:0] prod;
    prod = {32'h0, x} * {32'h0, y};
    return word_t'(prod % MOD64);
  endfunction

  function automatic word_t model_mod_add(input word_t x, input word_t y);
    logic [63:0] sum;
    sum = {32'h0, x} + {32'h0, y};
    return word_t'(sum % MOD64);
  endfunction

  // da = s*i*(1 - a^2) mod P
  function automatic word_t model_da(input word_t a, input word_t i, input word_t s);
    word_t sq;
    word_t one_minus_sq;
    sq           = model_mod_mul(a, a);
    one_minus_sq = word_t'((64'd1 + MOD64 - {32'h0, sq}) % MOD64);
    return model_mod_mul(model_mod_mul(s, i), one_minus_sq);
  endfunction

  // dW, dK and dB over the stored samples
  task automatic compute_expected(input int n);
    word_t da;
    int    t;
    exp_w = '0;
    exp_k = '0;
    exp_b = '0;
    for (t = 0; t < n; t++) begin
      da    = model_da(samp_a[t], samp_i[t], samp_s[t]);
      exp_w = model_mod_add(exp_w, model_mod_mul(da, samp_x[t]));
      exp_b = model_mod_add(exp_b, da);
      // Recurrent term pairs da(t) with h(t-1)
      if (t > 0) begin
        exp_k = model_mod_add(exp_k, model_mod_mul(da, samp_h[t-1]));
      end
    end
  endtask

  ////////////////////
  // Checks
  ////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic compare_word(input string test, input string field,
                              input word_t expected, input word_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("FAIL %s %s: expected %h, actual %h",
                               test, field, expected, actual));
    end
  endtask

  task automatic compare_bit(input string test, input string field,
                             input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("FAIL %s %s: expected %b, actual %b",
                               test, field, expected, actual));
    end
  endtask

  // Results sampled mid-cycle away from the rising edge
  always @(negedge CLK) begin
    if (RST === 1'b0 && ready === 1'b1) begin
      if (runs_checked == runs_started) begin
        report_failure("The ready output pulsed while no run was in progress");
      end else begin
        compare_word(cur_test, "w_out", exp_w, w_out);
        compare_word(cur_test, "k_out", exp_k, k_out);
        compare_word(cur_test, "b_out", exp_b, b_out);
        runs_checked = runs_checked + 1;
      end
    end
  end

  // Hard stop for a hung run
  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      report_failure($sformatf("The run did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic fill_random(input int n);
    int t;
    for (t = 0; t < n; t++) begin
      samp_a[t] = $urandom();
      samp_i[t] = $urandom();
      samp_s[t] = $urandom();
      samp_x[t] = $urandom();
      samp_h[t] = $urandom();
    end
  endtask

  task automatic wait_sample_ready();
    int waited;
    waited = 0;
    while (sample_ready !== 1'b1) begin
      @(negedge CLK);
      waited++;
      if (waited > SAMPLE_WAIT_LIMIT) begin
        report_failure($sformatf("Test %s waited too long for sample_ready to rise",
                                 cur_test));
      end
    end
  endtask

  // One run from start to the checked ready pulse
  task automatic run_test(input string name, input int n, input int max_gap);
    int gap;
    int t;
    compute_expected(n);
    cur_test     = name;
    runs_started = runs_started + 1;
    @(negedge CLK);
    length_in = count_t'(n);
    start     = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    // Empty run finishes two cycles after start
    if (n == 0) begin
      compare_bit(name, "ready one cycle after start", 1'b0, ready);
      @(negedge CLK);
      compare_bit(name, "ready two cycles after start", 1'b1, ready);
    end
    for (t = 0; t < n; t++) begin
      gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
      wait_sample_ready();
      // Source stays idle while sample_ready is already high
      repeat (gap) @(negedge CLK);
      a_in      = samp_a[t];
      i_in      = samp_i[t];
      s_in      = samp_s[t];
      x_in      = samp_x[t];
      h_in      = samp_h[t];
      in_enable = 1'b1;
      @(negedge CLK);
      in_enable = 1'b0;
    end
    while (runs_checked != runs_started) @(posedge CLK);
  endtask

  initial begin
    void'($urandom(32'h521d_609a));
    RST       = 1'b1;
    start     = 1'b0;
    length_in = '0;
    in_enable = 1'b0;
    a_in      = '0;
    i_in      = '0;
    s_in      = '0;
    x_in      = '0;
    h_in      = '0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Quiet outputs out of reset
    compare_bit("reset", "ready", 1'b0, ready);
    compare_bit("reset", "sample_ready", 1'b0, sample_ready);
    compare_word("reset", "w_out", '0, w_out);
    compare_word("reset", "k_out", '0, k_out);
    compare_word("reset", "b_out", '0, b_out);

    fill_random(LEN_SINGLE);
    run_test("single", LEN_SINGLE, 0);

    fill_random(LEN_RANDOM);
    run_test("random8", LEN_RANDOM, 0);

    // a of 1 or P-1 kills da and a of 0 leaves s*i
    fill_random(LEN_CORNER);
    samp_a[0] = word_t'(1);
    samp_a[1] = `NTM_MODULUS - word_t'(1);
    samp_a[2] = '0;
    samp_a[3] = `NTM_MODULUS - word_t'(1);
    samp_s[3] = `NTM_MODULUS - word_t'(1);
    samp_i[3] = `NTM_MODULUS - word_t'(1);
    samp_a[4] = '0;
    samp_s[4] = `NTM_MODULUS - word_t'(1);
    samp_i[4] = `NTM_MODULUS - word_t'(1);
    samp_a[5] = `NTM_MODULUS;
    run_test("corners", LEN_CORNER, 0);

    run_test("zero_length", 0, 0);

    // Two runs in a row must each start from cleared sums
    fill_random(LEN_GAPS);
    run_test("gaps_first", LEN_GAPS, 20);
    fill_random(LEN_GAPS);
    run_test("gaps_second", LEN_GAPS, 20);

    $display("Test passed");
    $finish;
  end

endmodule
